// File: vlog.f
+incdir+hdl
hdl/div_types_pkg.sv
hdl/div_ctrl_pkg.sv
hdl/div_operand_prep.sv
hdl/div_iter_kernel.sv
hdl/div_result_stage.sv
hdl/div_seq_fsm.sv
hdl/div_unit.sv
test/div_tb.sv

// File: Makefile
# Verilator flow for the divide unit

TOP = div_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing -f vlog.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir

// File: test/div_tb.sv
// Divider testbench
// Table-driven and random requests against a reference model,
// with writeback back-pressure and busy-time request offers

`timescale 1ns/1ps

module div_tb;

  import div_types_pkg::*;

  localparam int num_rand = 40;

  typedef struct packed {
    div_op_t    op;
    xlen_t      src0;
    xlen_t      src1;
    tag_t       tag;
    logic [3:0] delay;
    xlen_t      expected;
  } vec_t;

  logic     div_clk;
  logic     cpurst_b;
  logic     req_vld;
  div_req_t req;
  logic     full;
  logic     res_vld;
  div_res_t res;
  logic     res_grant;

  vec_t        vecs[$];
  logic [63:0] lcg_state;
  int          cycles;
  int          limit;
  int          accept_cnt;
  int          result_cnt;
  logic        res_vld_d;

  div_unit dut (
    .div_clk   (div_clk),
    .cpurst_b  (cpurst_b),
    .req_vld   (req_vld),
    .req       (req),
    .full      (full),
    .res_vld   (res_vld),
    .res       (res),
    .res_grant (res_grant)
  );

  initial
  begin
    div_clk = 1'b0;
    forever #20 div_clk = ~div_clk;
  end

  //======================================================================
  // Cycle limit and handshake counters
  //======================================================================
  always @(posedge div_clk)
  begin
    cycles++;
    if (cycles >= limit)
    begin
      $display("Timeout: the divider did not finish within %0d cycles", limit);
      $display("Regression failed");
      $fatal(1, "Simulation stopped at the cycle limit");
    end
    if (cpurst_b && req_vld && !full)
      accept_cnt++;
    // A result counts once, when it first appears
    if (cpurst_b && res_vld && !res_vld_d)
      result_cnt++;
    res_vld_d = res_vld;
  end

  task automatic check(input string name, input logic [63:0] actual,
                       input logic [63:0] expected);
    if (actual !== expected)
    begin
      $display("ERROR %s: got %h, expected %h", name, actual, expected);
      $display("Regression failed");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  function automatic logic [63:0] lcg_next();
    lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
    return lcg_state;
  endfunction

  // Truncating division with the special cases resolved first
  function automatic xlen_t ref_div(input div_op_t op, input xlen_t a, input xlen_t b);
    xlen_t x;
    xlen_t y;
    xlen_t q;
    xlen_t r;
    xlen_t mn;
    xlen_t value;
    x = a;
    y = b;
    if (op.word_op)
    begin
      x = op.signed_op ? {{32{a[31]}}, a[31:0]} : {32'd0, a[31:0]};
      y = op.signed_op ? {{32{b[31]}}, b[31:0]} : {32'd0, b[31:0]};
    end
    mn = op.word_op ? 64'hFFFFFFFF_80000000 : 64'h80000000_00000000;
    if (y == '0)
    begin
      q = '1;
      r = x;
    end
    else if (op.signed_op && (x == mn) && (y == '1))
    begin
      q = mn;
      r = '0;
    end
    else if (x == '0)
    begin
      q = '0;
      r = '0;
    end
    else if (op.signed_op)
    begin
      q = $signed(x) / $signed(y);
      r = $signed(x) % $signed(y);
    end
    else
    begin
      q = x / y;
      r = x % y;
    end
    value = op.sel_quotient ? q : r;
    if (op.word_op)
      value = {{32{value[31]}}, value[31:0]};
    return value;
  endfunction

  // Op bits in order signed, quotient and word
  task automatic add_vec(input logic [2:0] op, input xlen_t a, input xlen_t b,
                         input tag_t tag, input logic [3:0] delay, input xlen_t expected);
    vec_t v;
    v.op       = op;
    v.src0     = a;
    v.src1     = b;
    v.tag      = tag;
    v.delay    = delay;
    v.expected = expected;
    vecs.push_back(v);
  endtask

  // Starts at a falling edge and returns at the falling edge after the grant
  task automatic run_req(input div_op_t op, input xlen_t a, input xlen_t b,
                         input tag_t tag, input int delay, input xlen_t expected);
    div_res_t held;
    check("full", 64'(full), 64'd0);
    req_vld  = 1'b1;
    req.op   = op;
    req.src0 = a;
    req.src1 = b;
    req.tag  = tag;
    @(negedge div_clk);
    // Another request stays offered while the unit is busy
    req.tag  = ~tag;
    req.src0 = ~a;
    check("full", 64'(full), 64'd1);
    while (!res_vld)
    begin
      @(negedge div_clk);
      check("full", 64'(full), 64'd1);
    end
    check("res.data", res.data, expected);
    check("res.tag", 64'(res.tag), 64'(tag));
    held = res;
    for (int k = 0; k < delay; k++)
    begin
      @(negedge div_clk);
      check("res_vld", 64'(res_vld), 64'd1);
      check("res.data", res.data, held.data);
      check("res.tag", 64'(res.tag), 64'(held.tag));
      check("full", 64'(full), 64'd1);
    end
    res_grant = 1'b1;
    @(negedge div_clk);
    res_grant = 1'b0;
    req_vld   = 1'b0;
    check("res_vld", 64'(res_vld), 64'd0);
    check("full", 64'(full), 64'd0);
  endtask

  //======================================================================
  // Main sequence
  //======================================================================
  initial
  begin
    logic [63:0] r;
    xlen_t       a;
    xlen_t       b;
    div_op_t     op;
    int          max_delay;
    cpurst_b   = 1'b0;
    req_vld    = 1'b0;
    req        = '0;
    res_grant  = 1'b0;
    lcg_state  = 64'd81;
    cycles     = 0;
    accept_cnt = 0;
    result_cnt = 0;
    res_vld_d  = 1'b0;

    add_vec(3'b010, 64'd100, 64'd7, 5'd1, 4'd0, 64'hE);
    add_vec(3'b000, 64'd100, 64'd7, 5'd2, 4'd2, 64'd2);
    add_vec(3'b110, 64'hFFFFFFFF_FFFFFF9C, 64'd7, 5'd3, 4'd1, 64'hFFFFFFFF_FFFFFFF2);
    add_vec(3'b100, 64'hFFFFFFFF_FFFFFF9C, 64'd7, 5'd4, 4'd0, 64'hFFFFFFFF_FFFFFFFE);
    add_vec(3'b110, 64'd100, 64'hFFFFFFFF_FFFFFFF9, 5'd5, 4'd0, 64'hFFFFFFFF_FFFFFFF2);
    add_vec(3'b100, 64'd100, 64'hFFFFFFFF_FFFFFFF9, 5'd6, 4'd3, 64'd2);
    add_vec(3'b010, 64'd1, 64'd3, 5'd7, 4'd0, 64'd0);
    add_vec(3'b000, 64'd1, 64'd3, 5'd8, 4'd1, 64'd1);
    add_vec(3'b110, 64'hFFFFFFFF_FFFFFFFF, 64'hFFFFFFFF_FFFFFFFF, 5'd9, 4'd0, 64'd1);
    add_vec(3'b010, 64'hFFFFFFFF_FFFFFFFF, 64'h10, 5'd10, 4'd5, 64'h0FFFFFFF_FFFFFFFF);
    add_vec(3'b000, 64'h12345678_9ABCDEF0, 64'h100, 5'd11, 4'd0, 64'hF0);
    add_vec(3'b010, 64'h80000000_00000000, 64'd3, 5'd12, 4'd1, 64'h2AAAAAAA_AAAAAAAA);
    add_vec(3'b000, 64'd5, 64'h80000000_00000000, 5'd13, 4'd0, 64'd5);
    // Word operations with junk in the upper source bits
    add_vec(3'b011, 64'hDEAD0000_00000064, 64'hBEEF0000_00000007, 5'd14, 4'd0, 64'hE);
    add_vec(3'b111, 64'h12345678_FFFFFF9C, 64'h00000001_00000007, 5'd15, 4'd2,
            64'hFFFFFFFF_FFFFFFF2);
    add_vec(3'b011, 64'h00000001_FFFFFFFE, 64'hFFFFFFFF_00000001, 5'd16, 4'd0,
            64'hFFFFFFFF_FFFFFFFE);
    add_vec(3'b101, 64'hAAAAAAAA_FFFFFFF9, 64'h55555555_00000002, 5'd17, 4'd1,
            64'hFFFFFFFF_FFFFFFFF);
    // Divide by zero
    add_vec(3'b010, 64'd42, 64'd0, 5'd18, 4'd0, 64'hFFFFFFFF_FFFFFFFF);
    add_vec(3'b100, 64'hFFFFFFFF_FFFFFFFB, 64'd0, 5'd19, 4'd4, 64'hFFFFFFFF_FFFFFFFB);
    add_vec(3'b001, 64'hFFFF0000_80000000, 64'h12345678_00000000, 5'd20, 4'd0,
            64'hFFFFFFFF_80000000);
    add_vec(3'b011, 64'd5, 64'hFFFFFFFF_00000000, 5'd21, 4'd0, 64'hFFFFFFFF_FFFFFFFF);
    // Signed overflow
    add_vec(3'b110, 64'h80000000_00000000, 64'hFFFFFFFF_FFFFFFFF, 5'd22, 4'd0,
            64'h80000000_00000000);
    add_vec(3'b100, 64'h80000000_00000000, 64'hFFFFFFFF_FFFFFFFF, 5'd23, 4'd2, 64'd0);
    add_vec(3'b111, 64'h00000000_80000000, 64'h00000000_FFFFFFFF, 5'd24, 4'd0,
            64'hFFFFFFFF_80000000);
    add_vec(3'b101, 64'h77777777_80000000, 64'h00000001_FFFFFFFF, 5'd25, 4'd1, 64'd0);
    // Zero dividend
    add_vec(3'b110, 64'd0, 64'd9, 5'd26, 4'd0, 64'd0);
    add_vec(3'b101, 64'hFFFFFFFF_00000000, 64'd3, 5'd27, 4'd0, 64'd0);

    max_delay = 3;
    foreach (vecs[n])
      if (int'(vecs[n].delay) > max_delay)
        max_delay = int'(vecs[n].delay);
    limit = (vecs.size() + num_rand) * (70 + max_delay) + 10;

    repeat (4) @(negedge div_clk);
    check("full", 64'(full), 64'd0);
    check("res_vld", 64'(res_vld), 64'd0);
    cpurst_b = 1'b1;
    @(negedge div_clk);
    check("full", 64'(full), 64'd0);
    check("res_vld", 64'(res_vld), 64'd0);

    foreach (vecs[n])
      run_req(vecs[n].op, vecs[n].src0, vecs[n].src1, vecs[n].tag,
              int'(vecs[n].delay), vecs[n].expected);

    // Random requests with small operands on every other one
    for (int i = 0; i < num_rand; i++)
    begin
      r  = lcg_next();
      op = r[63:61];
      a  = lcg_next();
      b  = lcg_next();
      if (i % 2 == 0)
      begin
        a = a & 64'hFFF;
        b = b & 64'hF;
      end
      else
        b = b >> r[5:0];
      run_req(op, a, b, tag_t'(i), int'(r[9:8]), ref_div(op, a, b));
    end

    repeat (2) @(negedge div_clk);
    check("accepted requests", 64'(accept_cnt), 64'(vecs.size() + num_rand));
    check("results", 64'(result_cnt), 64'(accept_cnt));
    $display("Regression passed");
    $finish;
  end

endmodule

// File: hdl/div_unit.sv
// Iterative integer divide unit
// Sequencer, operand preparation, iteration kernel and result stage

`timescale 1ns/1ps

module div_unit (
  input  logic                    div_clk,
  input  logic                    cpurst_b,
  input  logic                    req_vld,
  input  div_types_pkg::div_req_t req,
  output logic                    full,
  output logic                    res_vld,
  output div_types_pkg::div_res_t res,
  input  logic                    res_grant
);

  import div_types_pkg::*;
  import div_ctrl_pkg::*;

  div_prep_t prep;
  special_e  special;
  logic      accept;
  logic      start;
  logic      done;
  xlen_t     quotient;
  xlen_t     remainder;

  div_seq_fsm u_seq (
    .div_clk   (div_clk),
    .cpurst_b  (cpurst_b),
    .req_vld   (req_vld),
    .special   (special),
    .done      (done),
    .res_vld   (res_vld),
    .res_grant (res_grant),
    .accept    (accept),
    .start     (start),
    .full      (full)
  );

  div_operand_prep u_prep (
    .req     (req),
    .prep    (prep),
    .special (special)
  );

  div_iter_kernel u_kernel (
    .div_clk      (div_clk),
    .cpurst_b     (cpurst_b),
    .start        (start),
    .dividend_abs (prep.dividend_abs),
    .divisor_abs  (prep.divisor_abs),
    .done         (done),
    .quotient     (quotient),
    .remainder    (remainder)
  );

  div_result_stage u_result (
    .div_clk   (div_clk),
    .cpurst_b  (cpurst_b),
    .accept    (accept),
    .req       (req),
    .prep      (prep),
    .special   (special),
    .done      (done),
    .quotient  (quotient),
    .remainder (remainder),
    .res_grant (res_grant),
    .res_vld   (res_vld),
    .res       (res)
  );

endmodule

// File: hdl/div_seq_fsm.sv
// Divider sequencer
// Accepts one request at a time and steps through iterate and writeback

`timescale 1ns/1ps

module div_seq_fsm (
  input  logic                   div_clk,
  input  logic                   cpurst_b,
  input  logic                   req_vld,
  input  div_ctrl_pkg::special_e special,
  input  logic                   done,
  input  logic                   res_vld,
  input  logic                   res_grant,
  output logic                   accept,
  output logic                   start,
  output logic                   full
);

  import div_ctrl_pkg::*;

  div_state_e state;
  div_state_e state_nxt;

  assign full   = (state != DIV_IDLE);
  assign accept = req_vld && (state == DIV_IDLE);
  // Special cases skip the kernel
  assign start  = accept && (special == SPC_NONE);

  always_comb
  begin
    state_nxt = state;
    case (state)
      DIV_IDLE:
      begin
        if (start)
          state_nxt = DIV_ITER;
        else if (accept)
          state_nxt = DIV_WAIT_WB;
      end
      DIV_ITER:
      begin
        if (done)
          state_nxt = DIV_WAIT_WB;
      end
      DIV_WAIT_WB:
      begin
        if (res_vld && res_grant)
          state_nxt = DIV_IDLE;
      end
      default:
        state_nxt = DIV_IDLE;
    endcase
  end

  always_ff @(posedge div_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      state <= DIV_IDLE;
    else
      state <= state_nxt;
  end

endmodule

// File: hdl/div_result_stage.sv
// Divider result stage
// Applies signs, word fixup or the special value and holds the
// result on the writeback port until it is granted

`timescale 1ns/1ps

`include "div_defines.svh"

module div_result_stage (
  input  logic                     div_clk,
  input  logic                     cpurst_b,
  input  logic                     accept,
  input  div_types_pkg::div_req_t  req,
  input  div_types_pkg::div_prep_t prep,
  input  div_ctrl_pkg::special_e   special,
  input  logic                     done,
  input  div_types_pkg::xlen_t     quotient,
  input  div_types_pkg::xlen_t     remainder,
  input  logic                     res_grant,
  output logic                     res_vld,
  output div_types_pkg::div_res_t  res
);

  import div_types_pkg::*;
  import div_ctrl_pkg::*;

  localparam int hi_w = `DIV_XLEN - `DIV_WORD_W;

  logic    vld_q;
  tag_t    tag_q;
  div_op_t op_q;
  logic    qneg_q;
  logic    rneg_q;
  xlen_t   data_q;
  xlen_t   most_neg;
  xlen_t   spc_raw;
  xlen_t   quo_signed;
  xlen_t   rem_signed;
  xlen_t   norm_raw;
  logic    spc_load;

  function automatic xlen_t word_fix(input xlen_t value, input logic word);
    word_fix = word ? {{hi_w{value[`DIV_WORD_W-1]}}, value[`DIV_WORD_W-1:0]} : value;
  endfunction

  //======================================================================
  // Special values
  //======================================================================
  assign most_neg = xlen_t'(1) << (req.op.word_op ? `DIV_WORD_W - 1 : `DIV_XLEN - 1);
  assign spc_load = accept && (special != SPC_NONE);

  always_comb
  begin
    case (special)
      SPC_DIV_ZERO: spc_raw = req.op.sel_quotient ? '1 : prep.dividend_norm;
      SPC_OVERFLOW: spc_raw = req.op.sel_quotient ? most_neg : '0;
      default:      spc_raw = '0;
    endcase
  end

  //======================================================================
  // Normal result fixup
  //======================================================================
  assign quo_signed = qneg_q ? (~quotient + xlen_t'(1)) : quotient;
  assign rem_signed = rneg_q ? (~remainder + xlen_t'(1)) : remainder;
  assign norm_raw   = op_q.sel_quotient ? quo_signed : rem_signed;

  // Operation context for the iterating path
  always_ff @(posedge div_clk)
  begin
    if (accept)
    begin
      tag_q  <= req.tag;
      op_q   <= req.op;
      qneg_q <= prep.quotient_neg;
      rneg_q <= prep.remainder_neg;
    end
  end

  always_ff @(posedge div_clk)
  begin
    if (spc_load)
      data_q <= word_fix(spc_raw, req.op.word_op);
    else if (done)
      data_q <= word_fix(norm_raw, op_q.word_op);
  end

  // Held valid, dropped once granted
  always_ff @(posedge div_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      vld_q <= 1'b0;
    else if (spc_load || done)
      vld_q <= 1'b1;
    else if (res_grant)
      vld_q <= 1'b0;
  end

  assign res_vld  = vld_q;
  assign res.data = data_q;
  assign res.tag  = tag_q;

endmodule

// File: hdl/div_iter_kernel.sv
// Divider iteration kernel
// Normalises the dividend to its leading one, then runs one
// shift-subtract step per cycle on the magnitudes

`timescale 1ns/1ps

`include "div_defines.svh"

module div_iter_kernel (
  input  logic                 div_clk,
  input  logic                 cpurst_b,
  input  logic                 start,
  input  div_types_pkg::xlen_t dividend_abs,
  input  div_types_pkg::xlen_t divisor_abs,
  output logic                 done,
  output div_types_pkg::xlen_t quotient,
  output div_types_pkg::xlen_t remainder
);

  import div_types_pkg::*;

  logic                busy;
  iter_cnt_t           cnt;
  iter_cnt_t           lead_pos;
  iter_cnt_t           pre_shift;
  xlen_t               dvd_q;
  xlen_t               dsr_q;
  xlen_t               rem_q;
  xlen_t               quo_q;
  logic [`DIV_XLEN:0]  part;
  logic [`DIV_XLEN:0]  diff;
  logic                take;
  xlen_t               rem_nxt;
  xlen_t               quo_nxt;

  //======================================================================
  // Leading one of the dividend
  //======================================================================
  // Highest set bit wins
  always_comb
  begin
    lead_pos = '0;
    for (int i = 0; i < `DIV_XLEN; i++)
    begin
      if (dividend_abs[i])
        lead_pos = iter_cnt_t'(i);
    end
  end

  assign pre_shift = iter_cnt_t'(`DIV_XLEN - 1) - lead_pos;

  //======================================================================
  // Shift-subtract step
  //======================================================================
  // Partial remainder needs one extra bit before the compare
  assign part    = {rem_q, dvd_q[`DIV_XLEN-1]};
  assign diff    = part - {1'b0, dsr_q};
  assign take    = ~diff[`DIV_XLEN];
  assign rem_nxt = take ? diff[`DIV_XLEN-1:0] : part[`DIV_XLEN-1:0];
  assign quo_nxt = {quo_q[`DIV_XLEN-2:0], take};

  // Last step results leave combinationally with done
  assign done      = busy && (cnt == iter_cnt_t'(1));
  assign quotient  = quo_nxt;
  assign remainder = rem_nxt;

  always_ff @(posedge div_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      busy <= 1'b0;
      cnt  <= '0;
    end
    else if (start)
    begin
      busy <= 1'b1;
      cnt  <= lead_pos + iter_cnt_t'(1);
    end
    else if (busy)
    begin
      busy <= ~done;
      cnt  <= cnt - iter_cnt_t'(1);
    end
  end

  always_ff @(posedge div_clk)
  begin
    if (start)
    begin
      dvd_q <= dividend_abs << pre_shift;
      dsr_q <= divisor_abs;
      rem_q <= '0;
      quo_q <= '0;
    end
    else if (busy)
    begin
      dvd_q <= dvd_q << 1;
      rem_q <= rem_nxt;
      quo_q <= quo_nxt;
    end
  end

endmodule

// File: hdl/div_operand_prep.sv
// Divider operand preparation
// Extends word operands, classifies special cases and forms
// magnitudes and result signs for the iteration kernel

`timescale 1ns/1ps

`include "div_defines.svh"

module div_operand_prep (
  input  div_types_pkg::div_req_t  req,
  output div_types_pkg::div_prep_t prep,
  output div_ctrl_pkg::special_e   special
);

  import div_types_pkg::*;
  import div_ctrl_pkg::*;

  localparam int hi_w = `DIV_XLEN - `DIV_WORD_W;

  xlen_t src0_ext;
  xlen_t src1_ext;
  xlen_t most_neg;
  logic  src0_neg;
  logic  src1_neg;

  //======================================================================
  // Word extension
  //======================================================================
  // Upper source bits are ignored for word operations
  always_comb
  begin
    src0_ext = req.src0;
    src1_ext = req.src1;
    if (req.op.word_op)
    begin
      src0_ext = {{hi_w{req.op.signed_op & req.src0[`DIV_WORD_W-1]}},
                  req.src0[`DIV_WORD_W-1:0]};
      src1_ext = {{hi_w{req.op.signed_op & req.src1[`DIV_WORD_W-1]}},
                  req.src1[`DIV_WORD_W-1:0]};
    end
  end

  //======================================================================
  // Special case detection
  //======================================================================
  assign most_neg = req.op.word_op ? {{(hi_w + 1){1'b1}}, {(`DIV_WORD_W-1){1'b0}}}
                                   : {1'b1, {(`DIV_XLEN-1){1'b0}}};

  // Priority: divisor zero, overflow, dividend zero
  always_comb
  begin
    if (src1_ext == '0)
      special = SPC_DIV_ZERO;
    else if (req.op.signed_op && (src0_ext == most_neg) && (src1_ext == '1))
      special = SPC_OVERFLOW;
    else if (src0_ext == '0)
      special = SPC_ZERO_DIVIDEND;
    else
      special = SPC_NONE;
  end

  //======================================================================
  // Magnitudes and result signs
  //======================================================================
  assign src0_neg = req.op.signed_op & src0_ext[`DIV_XLEN-1];
  assign src1_neg = req.op.signed_op & src1_ext[`DIV_XLEN-1];

  assign prep.dividend_abs  = src0_neg ? (~src0_ext + xlen_t'(1)) : src0_ext;
  assign prep.divisor_abs   = src1_neg ? (~src1_ext + xlen_t'(1)) : src1_ext;
  // Quotient negative on differing signs, remainder follows dividend
  assign prep.quotient_neg  = src0_neg ^ src1_neg;
  assign prep.remainder_neg = src0_neg;
  assign prep.dividend_norm = src0_ext;

endmodule

// File: hdl/div_ctrl_pkg.sv
// Divider control types
// Sequencer states and special-case kinds

package div_ctrl_pkg;

  typedef enum logic [1:0] {
    DIV_IDLE    = 2'd0,
    DIV_ITER    = 2'd1,
    DIV_WAIT_WB = 2'd2
  } div_state_e;

  // Cases resolved without iterating
  typedef enum logic [1:0] {
    SPC_NONE          = 2'd0,
    SPC_OVERFLOW      = 2'd1,
    SPC_DIV_ZERO      = 2'd2,
    SPC_ZERO_DIVIDEND = 2'd3
  } special_e;

endpackage

// File: hdl/div_types_pkg.sv
// Divider data types
// Operand words, operation code, request, prepared operands and result

`include "div_defines.svh"

package div_types_pkg;

  typedef logic [`DIV_XLEN-1:0]  xlen_t;
  typedef logic [`DIV_TAG_W-1:0] tag_t;
  typedef logic [`DIV_CNT_W-1:0] iter_cnt_t;

  // Operation code bits
  typedef struct packed {
    logic signed_op;
    logic sel_quotient;
    logic word_op;
  } div_op_t;

  typedef struct packed {
    div_op_t op;
    xlen_t   src0;
    xlen_t   src1;
    tag_t    tag;
  } div_req_t;

  // Output of operand preparation
  typedef struct packed {
    xlen_t dividend_abs;
    xlen_t divisor_abs;
    logic  quotient_neg;
    logic  remainder_neg;
    xlen_t dividend_norm;
  } div_prep_t;

  typedef struct packed {
    xlen_t data;
    tag_t  tag;
  } div_res_t;

endpackage

// File: hdl/div_defines.svh
// Divider width definitions
// Operand, word, tag and iteration counter sizes

`ifndef DIV_DEFINES_SVH
`define DIV_DEFINES_SVH

// Full operand width
`define DIV_XLEN    64

// Word operation width, results sign-extend from its top bit
`define DIV_WORD_W  32

// Destination register tag
`define DIV_TAG_W   5

// Iteration counter, holds a count of up to 64
`define DIV_CNT_W   7

`endif
